// ==== source/zxmem_settings.svh ====
`ifndef ZXMEM_SETTINGS_SVH
`define ZXMEM_SETTINGS_SVH

// Register numbers on the machine's own register port
`define ZXM_REG_MASTERCONF    8'h00
`define ZXM_REG_MASTERMAPPER  8'h01

`define ZXM_PORT_DIVMMC       8'hE3   // Low address byte of the DivMMC control port

// DivMMC automapper trap addresses
`define ZXM_TRAP_RST00        16'h0000
`define ZXM_TRAP_RST08        16'h0008
`define ZXM_TRAP_RST38        16'h0038
`define ZXM_TRAP_NMI          16'h0066
`define ZXM_TRAP_TAPE_LOAD    16'h04C6
`define ZXM_TRAP_TAPE_SAVE    16'h0562
`define ZXM_TRAP_PAGE         8'h3D           // Instant mapping on the whole page
`define ZXM_TRAP_EXIT         13'h03FF        // 1FF8..1FFF, address bits 15:3

// Screen pages and SRAM region prefixes
`define ZXM_PAGE_SCREEN0      3'd5
`define ZXM_PAGE_SCREEN1      3'd7
`define ZXM_DIVMMC_ROM_BASE   6'b011000
`define ZXM_SRAM_ROM_BASE     3'b010

`endif

// ==== source/zxmem_pkg.sv ====
`default_nettype none

package zxmem_pkg;

   typedef logic [18:0] sram_addr_t;   // 512 KB external SRAM
   typedef logic [15:0] cpu_addr_t;    // Z80 address bus

   // Master configuration register image, bit 7 first
   typedef struct packed {
      logic frozen;
      logic timing_hi;
      logic disable_cont;
      logic timing_lo;
      logic issue2;
      logic nmi_disabled;
      logic divmmc_enabled;
      logic boot_mode;
   } masterconf_t;

   // What one quadrant mapper hands to the SRAM arbiter
   typedef struct packed {
      logic       hit;          // This quadrant owns the current CPU cycle
      sram_addr_t addr;
      logic       wr_protect;   // ROM or locked page
      logic       boot_sel;     // Data comes from the boot ROM
      logic       screen;       // Contended screen page
   } quad_route_t;

endpackage

`default_nettype wire

// ==== source/paging_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Paging state shared by the register block, automapper, mappers and arbiter
interface paging_if;

   zxmem_pkg::masterconf_t conf;
   logic [4:0]             mapper;        // 16 KB SRAM page seen at C000 in boot mode
   logic [7:0]             bank128;       // Port 7FFD
   logic [7:0]             bankplus3;     // Port 1FFD
   logic [7:0]             divmmc_ctrl;   // Port E3
   logic                   divmmc_paged;  // Automapper state

   // Register block and automapper side
   modport src (
      output conf, mapper, bank128, bankplus3, divmmc_ctrl, divmmc_paged
   );

   // Address decode and SRAM side
   modport dst (
      input conf, mapper, bank128, bankplus3, divmmc_ctrl, divmmc_paged
   );

endinterface

`default_nettype wire

// ==== source/paging_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "zxmem_settings.svh"

module paging_regs (
   input  wire                    clk,
   input  wire                    mrst_n,
   input  wire                    rst_n,
   input  wire zxmem_pkg::cpu_addr_t a,
   input  wire [7:0]              din,
   input  wire                    iorq_n,
   input  wire                    wr_n,
   input  wire [7:0]              addr,
   input  wire                    iow,
   input  wire                    page_configrom_active,
   paging_if.src                  pg,
   output logic [1:0]             timing_mode,
   output logic                   mode_has_changed,
   output logic                   disable_contention,
   output logic                   issue2_keyboard_enabled,
   output logic                   in_boot_mode
);

   logic io_wr;
   logic port_locked;
   logic wr_conf;
   logic wr_mapper;
   logic wr_7ffd;
   logic wr_1ffd;
   logic wr_divmmc;
   logic configrom_q;       // Config ROM signal one cycle ago
   logic configrom_fall;

   assign io_wr          = !iorq_n && !wr_n;
   assign port_locked    = pg.bank128[5];      // 48K lock
   assign configrom_fall = configrom_q && !page_configrom_active;

   // Partial decodes as on the original machines
   assign wr_7ffd   = io_wr && a[0] && !a[1] && a[14] && !a[15] && !port_locked;
   assign wr_1ffd   = io_wr && a[0] && !a[1] && a[12] && a[15:13] == 3'b000 && !port_locked;
   assign wr_divmmc = io_wr && a[7:0] == `ZXM_PORT_DIVMMC;
   assign wr_conf   = iow && addr == `ZXM_REG_MASTERCONF;
   assign wr_mapper = iow && addr == `ZXM_REG_MASTERMAPPER && pg.conf.boot_mode;

   ////////////////////////////////////////////////////////////
   // Master configuration
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      mode_has_changed <= 1'b0;
      if (!mrst_n) begin
         pg.conf          <= zxmem_pkg::masterconf_t'(8'h01);   // Boot mode only
         configrom_q      <= 1'b0;
         mode_has_changed <= 1'b1;
      end else begin
         configrom_q <= page_configrom_active;
         if (page_configrom_active) begin
            pg.conf.frozen    <= 1'b0;
            pg.conf.boot_mode <= 1'b1;
         end else if (configrom_fall) begin
            pg.conf.frozen    <= 1'b1;
            pg.conf.boot_mode <= 1'b0;
         end else if (wr_conf) begin
            mode_has_changed <= 1'b1;
            {pg.conf.timing_hi, pg.conf.disable_cont,
             pg.conf.timing_lo, pg.conf.issue2} <= din[6:3];
            if (!pg.conf.frozen) begin   // Freeze bit and boot bits lock together
               pg.conf.frozen <= din[7];
               {pg.conf.nmi_disabled, pg.conf.divmmc_enabled,
                pg.conf.boot_mode} <= din[2:0];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         pg.mapper <= 5'h00;
      end else if (wr_mapper) begin
         pg.mapper <= din[4:0];
      end
   end

   ////////////////////////////////////////////////////////////
   // Spectrum paging ports and DivMMC control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         pg.bank128     <= 8'h00;
         pg.bankplus3   <= 8'h00;
         pg.divmmc_ctrl <= 8'h00;
      end else begin
         if (wr_7ffd) pg.bank128 <= din;
         else if (wr_1ffd) pg.bankplus3 <= din;
         if (wr_divmmc) pg.divmmc_ctrl <= din;
      end
   end

   assign timing_mode             = {pg.conf.timing_hi, pg.conf.timing_lo};
   assign disable_contention      = pg.conf.disable_cont;
   assign issue2_keyboard_enabled = pg.conf.issue2;
   assign in_boot_mode            = !pg.conf.frozen;

endmodule

`default_nettype wire

// ==== source/divmmc_automap.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "zxmem_settings.svh"

module divmmc_automap (
   input  wire                    clk,
   input  wire                    mrst_n,
   input  wire                    rst_n,
   input  wire zxmem_pkg::cpu_addr_t a,
   input  wire                    mreq_n,
   input  wire                    rd_n,
   input  wire                    m1_n,
   input  wire                    page_configrom_active,
   paging_if.src                  pg,
   output logic                   enable_nmi_n
);

   logic fetch;
   logic trap_deferred;
   logic trap_instant;
   logic trap_exit;
   logic armed;           // State to take once the M1 cycle ends

   assign fetch = !mreq_n && !rd_n && !m1_n;

   assign trap_deferred = a == `ZXM_TRAP_RST00 || a == `ZXM_TRAP_RST08 ||
                          a == `ZXM_TRAP_RST38 ||
                          a == `ZXM_TRAP_TAPE_LOAD || a == `ZXM_TRAP_TAPE_SAVE ||
                          (a == `ZXM_TRAP_NMI && !pg.conf.nmi_disabled &&
                           !page_configrom_active);
   assign trap_instant  = a[15:8] == `ZXM_TRAP_PAGE;
   assign trap_exit     = a[15:3] == `ZXM_TRAP_EXIT;

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         armed           <= 1'b0;
         pg.divmmc_paged <= 1'b0;
      end else begin
         if (fetch && trap_deferred) begin
            armed <= 1'b1;
         end else if (fetch && trap_instant) begin   // Maps during this fetch
            armed           <= 1'b1;
            pg.divmmc_paged <= 1'b1;
         end else if (fetch && trap_exit) begin
            armed <= 1'b0;
         end
         if (m1_n) pg.divmmc_paged <= armed;        // Outside M1 the deferred state applies
      end
   end

   assign enable_nmi_n = pg.conf.divmmc_enabled & pg.divmmc_paged & ~pg.conf.nmi_disabled;

endmodule

`default_nettype wire

// ==== source/quadrant_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "zxmem_settings.svh"

module quadrant_mapper #(
   parameter int QUADRANT = 0
) (
   input  wire zxmem_pkg::cpu_addr_t a,
   input  wire                    mreq_n,
   paging_if.dst                  pg,
   output zxmem_pkg::quad_route_t route
);

   // +3 all-RAM pages, indexed by quadrant then by arrangement
   localparam logic [2:0] ALLRAM_PAGE [4][4] = '{
      '{3'd0, 3'd4, 3'd4, 3'd4},
      '{3'd1, 3'd5, 3'd5, 3'd7},
      '{3'd2, 3'd6, 3'd6, 3'd6},
      '{3'd3, 3'd7, 3'd3, 3'd3}
   };
   localparam logic [1:0] QSEL = QUADRANT[1:0];

   logic       selected;
   logic       allram;
   logic [1:0] arrangement;
   logic       conmem;
   logic       mapram;
   logic [3:0] divmmc_page;
   logic       divmmc_on;
   logic [2:0] std_page;    // Page outside all-RAM mode

   assign selected    = a[15:14] == QSEL;
   assign allram      = pg.bankplus3[0];
   assign arrangement = pg.bankplus3[2:1];
   assign conmem      = pg.divmmc_ctrl[7];
   assign mapram      = pg.divmmc_ctrl[6];
   assign divmmc_page = pg.divmmc_ctrl[3:0];
   assign divmmc_on   = pg.conf.divmmc_enabled && (pg.divmmc_paged || conmem);
   assign std_page    = (QUADRANT == 1) ? `ZXM_PAGE_SCREEN0 :
                        (QUADRANT == 2) ? 3'd2 : pg.bank128[2:0];

   always_comb begin
      route     = '0;
      route.hit = selected && !mreq_n;
      if (QUADRANT == 0) begin
         if (pg.conf.boot_mode) begin
            route.boot_sel   = 1'b1;
            route.wr_protect = 1'b1;
         end else if (divmmc_on && !a[13]) begin   // DivMMC ROM, or page 3 under mapram
            route.wr_protect = 1'b1;
            if (conmem || !mapram) route.addr = {`ZXM_DIVMMC_ROM_BASE, a[12:0]};
            else route.addr = {2'b10, 4'd3, a[12:0]};
         end else if (divmmc_on) begin
            route.addr       = {2'b10, divmmc_page, a[12:0]};
            route.wr_protect = !conmem && mapram && divmmc_page == 4'd3;
         end else if (!allram) begin
            route.addr       = {`ZXM_SRAM_ROM_BASE, pg.bankplus3[2], pg.bank128[4], a[13:0]};
            route.wr_protect = 1'b1;
         end else begin
            route.addr = {2'b00, ALLRAM_PAGE[0][arrangement], a[13:0]};
         end
      end else if (QUADRANT == 3 && pg.conf.boot_mode) begin
         route.addr = {pg.mapper, a[13:0]};   // Any SRAM page for the loader
      end else if (pg.conf.boot_mode || !allram) begin
         route.addr   = {2'b00, std_page, a[13:0]};
         // Contention applies to the screen pages outside boot
         route.screen = selected && !pg.conf.boot_mode &&
                        (std_page == `ZXM_PAGE_SCREEN0 || std_page == `ZXM_PAGE_SCREEN1);
      end else begin
         route.addr = {2'b00, ALLRAM_PAGE[QUADRANT][arrangement], a[13:0]};
      end
   end

endmodule

`default_nettype wire

// ==== source/sram_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "zxmem_settings.svh"

module sram_arbiter (
   input  wire                      clk,
   input  wire                      mrst_n,
   input  wire zxmem_pkg::quad_route_t routes [4],
   paging_if.dst                    pg,
   input  wire [13:0]               vramaddr,
   input  wire [7:0]                din,
   input  wire                      rd_n,
   input  wire                      wr_n,
   input  wire                      mreq_n,
   input  wire [7:0]                addr,
   input  wire                      ior,
   input  wire [7:0]                boot_rom_data,
   input  wire [7:0]                sram_rdata,
   output zxmem_pkg::sram_addr_t    sram_addr,
   output logic [7:0]               sram_wdata,
   output logic                     sram_we_n,
   output logic [7:0]               vramdout,
   output logic [7:0]               dout,
   output logic                     oe_n,
   output logic                     boot_rom_sel,
   output logic                     access_to_screen
);

   logic                   phase;       // 0 video slot, 1 CPU slot
   zxmem_pkg::quad_route_t cpu_route;
   zxmem_pkg::sram_addr_t  vid_addr;
   logic [7:0]             cpu_rdata;
   logic                   cpu_write;

   // At most one quadrant hits, so the last match is the only one
   always_comb begin
      cpu_route        = '0;
      access_to_screen = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (routes[i].hit) cpu_route = routes[i];
         access_to_screen = access_to_screen | routes[i].screen;
      end
   end

   assign vid_addr  = {3'b001, pg.bank128[3], 1'b1, vramaddr};   // Page 5 or 7
   assign cpu_write = !mreq_n && !wr_n && cpu_route.hit && !cpu_route.wr_protect;

   ////////////////////////////////////////////////////////////
   // SRAM time sharing
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!mrst_n) phase <= 1'b0;
      else phase <= ~phase;
   end

   assign sram_addr  = phase ? cpu_route.addr : vid_addr;
   assign sram_we_n  = !(phase && cpu_write);
   assign sram_wdata = din;

   always_ff @(posedge clk) begin
      if (phase) cpu_rdata <= sram_rdata;
      else vramdout <= sram_rdata;
   end

   ////////////////////////////////////////////////////////////
   // CPU read data
   ////////////////////////////////////////////////////////////
   assign boot_rom_sel = cpu_route.hit && cpu_route.boot_sel;

   always_comb begin
      dout = 8'hFF;
      oe_n = 1'b1;
      if (boot_rom_sel && !rd_n) begin
         dout = boot_rom_data;
         oe_n = 1'b0;
      end else if (cpu_route.hit && !rd_n) begin
         dout = cpu_rdata;
         oe_n = 1'b0;
      end else if (ior && addr == `ZXM_REG_MASTERCONF) begin
         dout = pg.conf;
         oe_n = 1'b0;
      end else if (ior && addr == `ZXM_REG_MASTERMAPPER) begin
         dout = {3'b000, pg.mapper};
         oe_n = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== source/zx_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module zx_memory (
   input  wire        clk,
   input  wire        mrst_n,
   input  wire        rst_n,
   input  wire [15:0] a,
   input  wire [7:0]  din,
   input  wire        mreq_n,
   input  wire        iorq_n,
   input  wire        rd_n,
   input  wire        wr_n,
   input  wire        m1_n,
   input  wire        page_configrom_active,
   input  wire [13:0] vramaddr,
   input  wire [7:0]  addr,
   input  wire        ior,
   input  wire        iow,
   input  wire [7:0]  boot_rom_data,
   input  wire [7:0]  sram_rdata,
   output wire [7:0]  dout,
   output wire        oe_n,
   output wire        enable_nmi_n,
   output wire        boot_rom_sel,
   output wire [7:0]  vramdout,
   output wire [1:0]  timing_mode,
   output wire        mode_has_changed,
   output wire        disable_contention,
   output wire        issue2_keyboard_enabled,
   output wire        access_to_screen,
   output wire        in_boot_mode,
   output wire [18:0] sram_addr,
   output wire [7:0]  sram_wdata,
   output wire        sram_we_n
);

   paging_if pg ();

   zxmem_pkg::quad_route_t routes [4];   // One per 16 KB quadrant

   paging_regs u_regs (
      .clk, .mrst_n, .rst_n, .a, .din, .iorq_n, .wr_n, .addr, .iow,
      .page_configrom_active, .pg, .timing_mode, .mode_has_changed,
      .disable_contention, .issue2_keyboard_enabled, .in_boot_mode
   );

   divmmc_automap u_automap (
      .clk, .mrst_n, .rst_n, .a, .mreq_n, .rd_n, .m1_n,
      .page_configrom_active, .pg, .enable_nmi_n
   );

   for (genvar q = 0; q < 4; q++) begin : g_quad
      quadrant_mapper #(.QUADRANT(q)) u_mapper (
         .a, .mreq_n, .pg, .route(routes[q])
      );
   end

   sram_arbiter u_arbiter (
      .clk, .mrst_n, .routes, .pg, .vramaddr, .din, .rd_n, .wr_n, .mreq_n,
      .addr, .ior, .boot_rom_data, .sram_rdata, .sram_addr, .sram_wdata,
      .sram_we_n, .vramdout, .dout, .oe_n, .boot_rom_sel, .access_to_screen
   );

endmodule

`default_nettype wire

// ==== verification/zx_memory_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module zx_memory_tb;

   localparam int K_IOW     = 0;    // CPU port write
   localparam int K_REGW    = 1;    // Register port write
   localparam int K_REGR    = 2;    // Register port readback
   localparam int K_MEMR    = 3;
   localparam int K_MEMW    = 4;
   localparam int K_MEMWP   = 5;    // Write that must not reach the SRAM
   localparam int K_BOOTR   = 6;
   localparam int K_FETCH   = 7;    // M1 fetch, then M1 released
   localparam int K_MODE    = 8;
   localparam int K_VIDEO   = 9;
   localparam int K_SOFTRST = 10;

   logic        clk;
   logic        mrst_n;
   logic        rst_n;
   logic [15:0] a;
   logic [7:0]  din;
   logic        mreq_n;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic        m1_n;
   logic        page_configrom_active;
   logic [13:0] vramaddr;
   logic [7:0]  addr;
   logic        ior;
   logic        iow;
   logic [7:0]  boot_rom_data;
   wire  [7:0]  sram_rdata;
   wire  [7:0]  dout;
   wire         oe_n;
   wire         enable_nmi_n;
   wire         boot_rom_sel;
   wire  [7:0]  vramdout;
   wire  [1:0]  timing_mode;
   wire         mode_has_changed;
   wire         disable_contention;
   wire         issue2_keyboard_enabled;
   wire         access_to_screen;
   wire         in_boot_mode;
   wire  [18:0] sram_addr;
   wire  [7:0]  sram_wdata;
   wire         sram_we_n;

   // Stimulus table, one entry per row in every queue
   string                 t_name [$];
   int                    t_kind [$];
   logic [15:0]           t_a    [$];
   logic [7:0]            t_data [$];
   zxmem_pkg::sram_addr_t t_exp  [$];
   logic                  t_flag [$];

   int                    errors;
   int                    checks;
   int                    write_count;
   zxmem_pkg::sram_addr_t last_waddr;
   logic [7:0]            last_wdata;

   zx_memory u_dut (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [7:0] sram_hash(input zxmem_pkg::sram_addr_t ad);
      logic [31:0] h;
      h = xorshift32(32'hc931_1322 ^ {13'h0000, ad});
      return h[31:24] ^ h[23:16] ^ h[15:8] ^ h[7:0];   // Every page bit reaches the byte
   endfunction

   ////////////////////////////////////////////////////////////
   // SRAM model
   ////////////////////////////////////////////////////////////
   assign sram_rdata = sram_hash(sram_addr);   // Contents are a hash of the address

   always @(posedge clk) begin
      if (!sram_we_n) begin
         last_waddr  <= sram_addr;
         last_wdata  <= sram_wdata;
         write_count <= write_count + 1;
      end
   end

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input zxmem_pkg::sram_addr_t exp,
                             input zxmem_pkg::sram_addr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic hold_cycles(input int n);
      for (int c = 0; c < n; c++) @(negedge clk);
   endtask

   task automatic idle_bus();
      a = 16'h0000;
      din = 8'h00;
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      m1_n = 1'b1;
      page_configrom_active = 1'b0;
      vramaddr = 14'h0000;
      addr = 8'h00;
      ior = 1'b0;
      iow = 1'b0;
      boot_rom_data = 8'h00;
      rst_n = 1'b1;
   endtask

   task automatic add_row(input string name, input int kind, input logic [15:0] av,
                          input logic [7:0] dv, input logic [18:0] ev, input logic fv);
      t_name.push_back(name);
      t_kind.push_back(kind);
      t_a.push_back(av);
      t_data.push_back(dv);
      t_exp.push_back(ev);
      t_flag.push_back(fv);
   endtask

   task automatic build_table();
      logic [2:0] page_tab [4][4];   // Arrangement, then quadrant
      logic [1:0] qa;
      logic [1:0] arr;
      page_tab = '{'{3'd0, 3'd1, 3'd2, 3'd3}, '{3'd4, 3'd5, 3'd6, 3'd7},
                   '{3'd4, 3'd5, 3'd6, 3'd3}, '{3'd4, 3'd7, 3'd6, 3'd3}};
      add_row("boot_rom_read", K_BOOTR, 16'h0123, 8'h5A, 19'h00000, 1'b1);
      add_row("conf_reset_value", K_REGR, 16'h0000, 8'h01, 19'h00000, 1'b0);
      add_row("mapper_write", K_REGW, 16'h0001, 8'h13, 19'h00000, 1'b0);
      add_row("mapper_readback", K_REGR, 16'h0001, 8'h13, 19'h00000, 1'b0);
      add_row("boot_quadrant3", K_MEMR, 16'hC456, 8'h00, 19'h4C456, 1'b0);
      add_row("boot_quadrant1", K_MEMR, 16'h4010, 8'h00, 19'h14010, 1'b0);
      add_row("conf_freeze", K_REGW, 16'h0000, 8'hAA, 19'h00000, 1'b1);
      add_row("conf_frozen_readback", K_REGR, 16'h0000, 8'hAA, 19'h00000, 1'b0);
      add_row("mode_after_freeze", K_MODE, 16'h0000, 8'h00, 19'h00003, 1'b0);
      add_row("conf_second_write", K_REGW, 16'h0000, 8'h55, 19'h00000, 1'b1);
      add_row("conf_masked_readback", K_REGR, 16'h0000, 8'hD2, 19'h00000, 1'b0);
      add_row("mode_after_second", K_MODE, 16'h0000, 8'h00, 19'h0000C, 1'b0);
      add_row("mapper_write_frozen", K_REGW, 16'h0001, 8'h1F, 19'h00000, 1'b0);
      add_row("mapper_unchanged", K_REGR, 16'h0001, 8'h13, 19'h00000, 1'b0);
      // 128K paging, then the lock bit
      add_row("select_bank7_rom1", K_IOW, 16'h7FFD, 8'h17, 19'h00000, 1'b0);
      add_row("bank7_read", K_MEMR, 16'hC100, 8'h00, 19'h1C100, 1'b1);
      add_row("rom1_read", K_MEMR, 16'h0200, 8'h00, 19'h24200, 1'b0);
      add_row("quadrant1_screen", K_MEMR, 16'h5000, 8'h00, 19'h15000, 1'b1);
      add_row("quadrant2_read", K_MEMR, 16'h8000, 8'h00, 19'h08000, 1'b0);
      add_row("select_bank5", K_IOW, 16'h7FFD, 8'h05, 19'h00000, 1'b0);
      add_row("bank5_read", K_MEMR, 16'hC200, 8'h00, 19'h14200, 1'b1);
      add_row("select_bank1_lock", K_IOW, 16'h7FFD, 8'h21, 19'h00000, 1'b0);
      add_row("bank1_read", K_MEMR, 16'hC010, 8'h00, 19'h04010, 1'b0);
      add_row("write_when_locked", K_IOW, 16'h7FFD, 8'h07, 19'h00000, 1'b0);
      add_row("bank1_still_read", K_MEMR, 16'hC010, 8'h00, 19'h04010, 1'b0);
      add_row("soft_reset", K_SOFTRST, 16'h0000, 8'h00, 19'h00000, 1'b0);
      add_row("video_page5", K_VIDEO, 16'h1ABC, 8'h00, 19'h15ABC, 1'b0);
      add_row("select_shadow_screen", K_IOW, 16'h7FFD, 8'h08, 19'h00000, 1'b0);
      add_row("video_page7", K_VIDEO, 16'h1ABC, 8'h00, 19'h1DABC, 1'b0);
      for (int r = 0; r < 4; r++) begin
         arr = 2'(r);
         add_row($sformatf("allram%0d_select", r), K_IOW, 16'h1FFD,
                 {5'b00000, arr, 1'b1}, 19'h00000, 1'b0);
         for (int q = 0; q < 4; q++) begin
            qa = 2'(q);
            add_row($sformatf("allram%0d_q%0d", r, q), K_MEMR, {qa, 14'h1234}, 8'h00,
                    {2'b00, page_tab[r][q], 14'h1234}, 1'b0);
         end
      end
      add_row("allram_off", K_IOW, 16'h1FFD, 8'h00, 19'h00000, 1'b0);
      // DivMMC automapper and its pages
      add_row("fetch_rst38", K_FETCH, 16'h0038, 8'h00, 19'h00000, 1'b1);
      add_row("divmmc_rom_read", K_MEMR, 16'h0100, 8'h00, 19'h30100, 1'b0);
      add_row("divmmc_rom_write", K_MEMWP, 16'h0200, 8'h77, 19'h00000, 1'b0);
      add_row("divmmc_page5", K_IOW, 16'h00E3, 8'h05, 19'h00000, 1'b0);
      add_row("divmmc_page_write", K_MEMW, 16'h2345, 8'h9C, 19'h4A345, 1'b0);
      add_row("divmmc_page_read", K_MEMR, 16'h2345, 8'h00, 19'h4A345, 1'b0);
      add_row("fetch_exit", K_FETCH, 16'h1FF8, 8'h00, 19'h00000, 1'b0);
      add_row("rom0_after_exit", K_MEMR, 16'h0100, 8'h00, 19'h20100, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // Row execution and checks
   ////////////////////////////////////////////////////////////
   task automatic run_row(input int i);
      int    start_writes;
      string nm;
      nm = t_name[i];
      start_writes = write_count;
      idle_bus();
      a = t_a[i];
      din = t_data[i];
      addr = t_a[i][7:0];
      case (t_kind[i])
         K_IOW: begin
            iorq_n = 1'b0;
            wr_n = 1'b0;
         end
         K_REGW:    iow = 1'b1;
         K_REGR:    ior = 1'b1;
         K_MEMR: begin
            mreq_n = 1'b0;
            rd_n = 1'b0;
         end
         K_MEMW, K_MEMWP: begin
            mreq_n = 1'b0;
            wr_n = 1'b0;
         end
         K_BOOTR: begin
            mreq_n = 1'b0;
            rd_n = 1'b0;
            boot_rom_data = t_data[i];
         end
         K_FETCH: begin
            mreq_n = 1'b0;
            rd_n = 1'b0;
            m1_n = 1'b0;
         end
         K_VIDEO:   vramaddr = t_a[i][13:0];
         K_SOFTRST: rst_n = 1'b0;
         default:   ;
      endcase
      if (t_kind[i] == K_FETCH) begin
         hold_cycles(2);
         idle_bus();   // End of M1 lets the deferred flag through
         hold_cycles(2);
      end else begin
         hold_cycles(4);
      end
      case (t_kind[i])
         K_REGW: check_bit({nm, "_mode_changed"}, t_flag[i], mode_has_changed);
         K_REGR: begin
            check_byte(nm, t_data[i], dout);
            check_bit({nm, "_oe_n"}, 1'b0, oe_n);
         end
         K_MEMR: begin
            check_byte(nm, sram_hash(t_exp[i]), dout);
            check_bit({nm, "_oe_n"}, 1'b0, oe_n);
            check_bit({nm, "_screen"}, t_flag[i], access_to_screen);
         end
         K_MEMW: begin
            check_bit({nm, "_written"}, 1'b1, write_count != start_writes);
            check_addr(nm, t_exp[i], last_waddr);
            check_byte({nm, "_data"}, t_data[i], last_wdata);
         end
         K_MEMWP: check_bit({nm, "_written"}, 1'b0, write_count != start_writes);
         K_BOOTR: begin
            check_bit({nm, "_sel"}, t_flag[i], boot_rom_sel);
            check_byte(nm, t_data[i], dout);
         end
         K_FETCH: check_bit({nm, "_enable_nmi_n"}, t_flag[i], enable_nmi_n);
         K_MODE: begin
            check_byte({nm, "_timing"}, {6'b000000, t_exp[i][3:2]}, {6'b000000, timing_mode});
            check_bit({nm, "_contention"}, t_exp[i][1], disable_contention);
            check_bit({nm, "_issue2"}, t_exp[i][0], issue2_keyboard_enabled);
            check_bit({nm, "_boot"}, t_flag[i], in_boot_mode);
            check_bit({nm, "_mode_changed"}, 1'b0, mode_has_changed);   // Pulse is over
         end
         K_VIDEO: check_byte(nm, sram_hash(t_exp[i]), vramdout);
         default: ;
      endcase
   endtask

   initial begin
      int c;
      clk = 1'b0;
      errors = 0;
      checks = 0;
      write_count = 0;
      last_waddr = 19'h00000;
      last_wdata = 8'h00;
      idle_bus();
      mrst_n = 1'b0;
      rst_n = 1'b0;
      build_table();
      hold_cycles(3);
      mrst_n = 1'b1;
      rst_n = 1'b1;
      for (c = 0; c < 10 && mode_has_changed; c++) @(negedge clk);
      if (mode_has_changed) begin
         errors++;
         $display("Timeout: mode_has_changed stayed high after reset");
      end
      for (int i = 0; i < t_name.size(); i++) run_row(i);
      idle_bus();
      hold_cycles(2);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/zxmem_pkg.sv
source/paging_if.sv
source/paging_regs.sv
source/divmmc_automap.sv
source/quadrant_mapper.sv
source/sram_arbiter.sv
source/zx_memory.sv
verification/zx_memory_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module zx_memory_tb -o zx_memory_sim
output=$(./obj_dir/zx_memory_sim)
echo "$output"
if echo "$output" | grep -q "^All tests passed$"; then
   exit 0
else
   exit 1
fi
